// File: Makefile
VERILATOR   ?= verilator
TOP         := rmt_tb
FILELIST    := tb.f
OBJ_DIR     := obj_dir
LOG         := sim.log
BUILD_FLAGS := --binary --timing --assert -j 0
LINT_FLAGS  := --lint-only --timing -Wall
RUN_FLAGS   := +verilator+error+limit+100
SOURCES     := $(shell cat $(FILELIST))

.PHONY: all lint clean

all: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TESTS PASSED" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: logic/deparser.sv
`timescale 1ns/1ps

module deparser import rmt_pkg::*; (
	input  logic              clk,
	input  logic              aresetn,
	input  beat_t             pkt_dout,
	input  logic              pkt_empty,
	output logic              pkt_rd_en,
	input  phv_t              phv_dout,
	input  logic              phv_empty,
	output logic              phv_rd_en,
	output logic [DATA_W-1:0] m_axis_tdata,
	output logic              m_axis_tlast,
	output logic              m_axis_tvalid,
	input  logic              m_axis_tready
);

	typedef enum logic {
		ST_HDR,
		ST_BODY
	} state_t;

	state_t state;
	state_t state_next;
	logic   xfer;

	// header beat waits for its vector, body beats only need the packet store
	assign m_axis_tvalid = !pkt_empty && ((state == ST_BODY) || !phv_empty);
	assign xfer = m_axis_tvalid && m_axis_tready;

	// beat comes off the store on each transfer
	assign pkt_rd_en = xfer;
	// vector retires with the last beat of its packet
	assign phv_rd_en = xfer && pkt_dout.last;

	// rewrite the header bits with the processed vector
	always_comb begin
		m_axis_tdata = pkt_dout.data;
		if (state == ST_HDR) begin
			m_axis_tdata[PHV_W-1:0] = phv_dout;
		end
	end

	assign m_axis_tlast = pkt_dout.last;

	always_comb begin
		state_next = state;
		if (xfer) begin
			// single-beat packets stay in the header state
			if (pkt_dout.last) begin
				state_next = ST_HDR;
			end else begin
				state_next = ST_BODY;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= ST_HDR;
		end else begin
			state <= state_next;
		end
	end

endmodule

// File: logic/fallthrough_fifo.sv
`timescale 1ns/1ps

module fallthrough_fifo #(
	parameter int DEPTH_BITS = 4,
	parameter int NEARLY_FULL_GAP = 1,
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     aresetn,
	input  payload_t din,
	input  logic     wr_en,
	input  logic     rd_en,
	output payload_t dout,
	output logic     empty,
	output logic     nearly_full
);

	localparam int DEPTH = 1 << DEPTH_BITS;

	payload_t              mem [DEPTH];
	logic [DEPTH_BITS-1:0] wr_ptr;
	logic [DEPTH_BITS-1:0] rd_ptr;
	logic [DEPTH_BITS:0]   count;
	logic                  full;
	logic                  do_wr;
	logic                  do_rd;

	assign full = (count == (DEPTH_BITS + 1)'(DEPTH));
	assign empty = (count == '0);
	// threshold on free slots, not on used ones
	assign nearly_full = (DEPTH - int'(count)) <= NEARLY_FULL_GAP;

	// writes into a full buffer are ignored
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// head shows without a read strobe
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// simultaneous read and write leaves count alone
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: logic/hdr_parser.sv
`timescale 1ns/1ps

module hdr_parser import rmt_pkg::*; (
	input  logic              clk,
	input  logic              aresetn,
	input  logic [DATA_W-1:0] s_axis_tdata,
	input  logic              s_axis_tlast,
	input  logic              s_axis_tvalid,
	output logic              s_axis_tready,
	input  logic              pkt_fifo_nearly_full,
	input  logic              phv_fifo_nearly_full,
	output logic              pkt_wr_en,
	output beat_t             pkt_din,
	output logic              phv_valid,
	output phv_t              phv
);

	logic first_beat;
	logic accept;
	logic hdr_accept;

	// hold off while either FIFO is close to full
	// vector FIFO gap already covers every vector still in the stages
	assign s_axis_tready = !(pkt_fifo_nearly_full || phv_fifo_nearly_full);
	assign accept = s_axis_tvalid && s_axis_tready;
	assign hdr_accept = accept && first_beat;

	// every beat goes straight into the packet store
	assign pkt_wr_en = accept;
	assign pkt_din = '{data: s_axis_tdata, last: s_axis_tlast};

	// next accepted beat after a last is a header beat
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			first_beat <= 1'b1;
		end else if (accept) begin
			first_beat <= s_axis_tlast;
		end
	end

	// one pulse per packet, a cycle after the header beat
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			phv_valid <= 1'b0;
		end else begin
			phv_valid <= hdr_accept;
		end
	end

	// low bits of the header beat become the vector
	always_ff @(posedge clk) begin
		if (hdr_accept) begin
			phv <= s_axis_tdata[PHV_W-1:0];
		end
	end

endmodule

// File: logic/match_stage.sv
`timescale 1ns/1ps

module match_stage import rmt_pkg::*; #(
	parameter int STAGE_ID = 0
) (
	input  logic clk,
	input  logic aresetn,
	input  logic phv_in_valid,
	input  phv_t phv_in,
	output logic phv_out_valid,
	output phv_t phv_out
);

	// container this stage works on
	localparam int SLOT = STAGE_ID % NUM_CONT;
	// fixed action constant, wraps at the container width
	localparam logic [CONT_W-1:0] INCR = CONT_W'(STAGE_ID + 1);

	phv_t phv_next;

	// other containers pass untouched
	always_comb begin
		phv_next = phv_in;
		phv_next[SLOT] = phv_in[SLOT] + INCR;
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			phv_out_valid <= 1'b0;
		end else begin
			phv_out_valid <= phv_in_valid;
		end
	end

	// vector only loads with a valid one
	always_ff @(posedge clk) begin
		if (phv_in_valid) begin
			phv_out <= phv_next;
		end
	end

endmodule

// File: logic/pkt_filter.sv
`timescale 1ns/1ps

module pkt_filter import rmt_pkg::*; (
	input  logic              clk,
	input  logic              aresetn,
	input  logic [FLAG_W-1:0] vlan_drop_flags,
	input  logic [DATA_W-1:0] s_axis_tdata,
	input  logic              s_axis_tlast,
	input  logic              s_axis_tvalid,
	output logic              s_axis_tready,
	output logic [DATA_W-1:0] m_axis_tdata,
	output logic              m_axis_tlast,
	output logic              m_axis_tvalid,
	input  logic              m_axis_tready
);

	logic              first_beat;
	logic              drop_pkt;
	logic              drop_beat;
	logic              advance;
	logic              accept;
	logic [VLAN_W-1:0] vlan_id;

	// only meaningful on the first beat
	assign vlan_id = s_axis_tdata[VLAN_W-1:0];

	// first beat decides from the mask, later beats follow the latched decision
	assign drop_beat = first_beat ? vlan_drop_flags[vlan_id[FLAG_SEL_W-1:0]] : drop_pkt;

	// output register free, or its beat leaves this cycle
	assign advance = !m_axis_tvalid || m_axis_tready;
	assign s_axis_tready = advance;
	assign accept = s_axis_tvalid && advance;

	// packet boundary tracking and drop latch
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			first_beat <= 1'b1;
			drop_pkt <= 1'b0;
		end else if (accept) begin
			first_beat <= s_axis_tlast;
			if (first_beat) begin
				drop_pkt <= drop_beat;
			end
		end
	end

	// dropped beats are swallowed, the slot stays empty
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			m_axis_tvalid <= 1'b0;
		end else if (advance) begin
			m_axis_tvalid <= accept && !drop_beat;
		end
	end

	// payload follows any accepted beat
	always_ff @(posedge clk) begin
		if (accept) begin
			m_axis_tdata <= s_axis_tdata;
			m_axis_tlast <= s_axis_tlast;
		end
	end

endmodule

// File: logic/rmt_pipeline.sv
`timescale 1ns/1ps

module rmt_pipeline import rmt_pkg::*; #(
	parameter int NUM_STAGES = 4,
	parameter int FIFO_DEPTH_BITS = 4
) (
	input  logic              clk,
	input  logic              aresetn,
	input  logic [FLAG_W-1:0] vlan_drop_flags,
	input  logic [DATA_W-1:0] s_axis_tdata,
	input  logic              s_axis_tlast,
	input  logic              s_axis_tvalid,
	output logic              s_axis_tready,
	output logic [DATA_W-1:0] m_axis_tdata,
	output logic              m_axis_tlast,
	output logic              m_axis_tvalid,
	input  logic              m_axis_tready
);

	// filtered stream into the parser
	logic [DATA_W-1:0] flt_tdata;
	logic              flt_tlast;
	logic              flt_tvalid;
	logic              flt_tready;

	// packet store
	logic  pkt_wr_en;
	beat_t pkt_din;
	beat_t pkt_dout;
	logic  pkt_rd_en;
	logic  pkt_empty;
	logic  pkt_nearly_full;

	// vector chain, index 0 from the parser, last index into the vector FIFO
	logic [NUM_STAGES:0] stg_valid;
	phv_t                stg_phv [NUM_STAGES+1];

	// vector FIFO
	phv_t phv_dout;
	logic phv_rd_en;
	logic phv_empty;
	logic phv_nearly_full;

	pkt_filter u_filter (
		.clk             (clk),
		.aresetn         (aresetn),
		.vlan_drop_flags (vlan_drop_flags),
		.s_axis_tdata    (s_axis_tdata),
		.s_axis_tlast    (s_axis_tlast),
		.s_axis_tvalid   (s_axis_tvalid),
		.s_axis_tready   (s_axis_tready),
		.m_axis_tdata    (flt_tdata),
		.m_axis_tlast    (flt_tlast),
		.m_axis_tvalid   (flt_tvalid),
		.m_axis_tready   (flt_tready)
	);

	hdr_parser u_parser (
		.clk                  (clk),
		.aresetn              (aresetn),
		.s_axis_tdata         (flt_tdata),
		.s_axis_tlast         (flt_tlast),
		.s_axis_tvalid        (flt_tvalid),
		.s_axis_tready        (flt_tready),
		.pkt_fifo_nearly_full (pkt_nearly_full),
		.phv_fifo_nearly_full (phv_nearly_full),
		.pkt_wr_en            (pkt_wr_en),
		.pkt_din              (pkt_din),
		.phv_valid            (stg_valid[0]),
		.phv                  (stg_phv[0])
	);

	fallthrough_fifo #(
		.DEPTH_BITS      (FIFO_DEPTH_BITS),
		.NEARLY_FULL_GAP (PKT_FIFO_GAP),
		.payload_t       (beat_t)
	) u_pkt_fifo (
		.clk         (clk),
		.aresetn     (aresetn),
		.din         (pkt_din),
		.wr_en       (pkt_wr_en),
		.rd_en       (pkt_rd_en),
		.dout        (pkt_dout),
		.empty       (pkt_empty),
		.nearly_full (pkt_nearly_full)
	);

	// stage k adds k+1 to container k mod 4, one cycle each
	for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
		match_stage #(
			.STAGE_ID (k)
		) u_stage (
			.clk           (clk),
			.aresetn       (aresetn),
			.phv_in_valid  (stg_valid[k]),
			.phv_in        (stg_phv[k]),
			.phv_out_valid (stg_valid[k+1]),
			.phv_out       (stg_phv[k+1])
		);
	end

	// room for every vector still travelling through the stages
	fallthrough_fifo #(
		.DEPTH_BITS      (FIFO_DEPTH_BITS),
		.NEARLY_FULL_GAP (NUM_STAGES + 2),
		.payload_t       (phv_t)
	) u_phv_fifo (
		.clk         (clk),
		.aresetn     (aresetn),
		.din         (stg_phv[NUM_STAGES]),
		.wr_en       (stg_valid[NUM_STAGES]),
		.rd_en       (phv_rd_en),
		.dout        (phv_dout),
		.empty       (phv_empty),
		.nearly_full (phv_nearly_full)
	);

	deparser u_deparser (
		.clk           (clk),
		.aresetn       (aresetn),
		.pkt_dout      (pkt_dout),
		.pkt_empty     (pkt_empty),
		.pkt_rd_en     (pkt_rd_en),
		.phv_dout      (phv_dout),
		.phv_empty     (phv_empty),
		.phv_rd_en     (phv_rd_en),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready)
	);

endmodule

// File: logic/rmt_pkg.sv
package rmt_pkg;

	// stream beat width
	localparam int DATA_W = 64;

	// header vector geometry
	localparam int CONT_W = 16;
	localparam int NUM_CONT = 4;
	// vector bits taken from the low end of the first beat
	localparam int PHV_W = NUM_CONT * CONT_W;

	// vlan id sits in the low bits of the first beat
	localparam int VLAN_W = 12;

	// drop mask, indexed by the low vlan id bits
	localparam int FLAG_W = 32;
	localparam int FLAG_SEL_W = $clog2(FLAG_W);

	// free slots kept back in the packet FIFO
	// one is enough since the parser writes in the cycle it accepts
	localparam int PKT_FIFO_GAP = 1;

	// one stream beat as stored in the packet FIFO
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic              last;
	} beat_t;

	// header vector, container 0 in the low bits
	typedef logic [NUM_CONT-1:0][CONT_W-1:0] phv_t;

endpackage

// File: tb.f
logic/rmt_pkg.sv
logic/fallthrough_fifo.sv
logic/pkt_filter.sv
logic/hdr_parser.sv
logic/match_stage.sv
logic/deparser.sv
logic/rmt_pipeline.sv
verif/rmt_sva.sv
verif/rmt_tb.sv

// File: verif/rmt_sva.sv
`timescale 1ns/1ps

module rmt_sva import rmt_pkg::*; (
	input logic              clk,
	input logic              aresetn,
	input logic              s_axis_tvalid,
	input logic              s_axis_tready,
	input logic [DATA_W-1:0] m_axis_tdata,
	input logic              m_axis_tlast,
	input logic              m_axis_tvalid,
	input logic              m_axis_tready
);

	// running count of failed properties
	int   fail_count = 0;
	logic seen_input;

	// set by the first accepted input beat
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			seen_input <= 1'b0;
		end else if (s_axis_tvalid && s_axis_tready) begin
			seen_input <= 1'b1;
		end
	end

	// stalled output beat holds
	a_hold: assert property (@(posedge clk) disable iff (!aresetn)
		m_axis_tvalid && !m_axis_tready |=>
			m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
	else begin
		fail_count++;
		$error("output beat changed while stalled");
	end

	// reset edge clears the output
	a_reset: assert property (@(posedge clk) !aresetn |=> !m_axis_tvalid)
	else begin
		fail_count++;
		$error("m_axis_tvalid high during reset");
	end

	// nothing out before anything went in
	a_no_spurious: assert property (@(posedge clk) disable iff (!aresetn)
		!seen_input |-> !m_axis_tvalid)
	else begin
		fail_count++;
		$error("output beat before any input beat");
	end

endmodule

bind rmt_pipeline rmt_sva u_sva (.*);

// File: verif/rmt_tb.sv
`timescale 1ns/1ps

module rmt_tb import rmt_pkg::*; ();

	localparam int SEED = 50;
	localparam int MEM_WORDS = 256;
	localparam int MAX_TESTS = 8;

	logic              clk;
	logic              aresetn;
	logic [FLAG_W-1:0] vlan_drop_flags;
	logic [DATA_W-1:0] s_axis_tdata;
	logic              s_axis_tlast;
	logic              s_axis_tvalid;
	logic              s_axis_tready;
	logic [DATA_W-1:0] m_axis_tdata;
	logic              m_axis_tlast;
	logic              m_axis_tvalid;
	logic              m_axis_tready;

	// raw words from the data file
	logic [63:0] td [MEM_WORDS];

	// input beats in send order with their test number
	beat_t in_q [$];
	int    in_test [$];
	// expected beats with a header flag each and one vector per header
	beat_t exp_q [$];
	bit    exp_hdr [$];
	phv_t  exp_phv [$];

	int num_tests;
	int test_mode [MAX_TESTS];
	// expected beats received by the end of each test
	int exp_cum [MAX_TESTS];
	int rcvd;
	int errors;
	int checks;
	int watchdog_cycles;
	bit stall_on;
	bit ready_fell;

	rmt_pipeline UUT (
		.clk             (clk),
		.aresetn         (aresetn),
		.vlan_drop_flags (vlan_drop_flags),
		.s_axis_tdata    (s_axis_tdata),
		.s_axis_tlast    (s_axis_tlast),
		.s_axis_tvalid   (s_axis_tvalid),
		.s_axis_tready   (s_axis_tready),
		.m_axis_tdata    (m_axis_tdata),
		.m_axis_tlast    (m_axis_tlast),
		.m_axis_tvalid   (m_axis_tvalid),
		.m_axis_tready   (m_axis_tready)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// ready one cycle in four during the back-pressure test
	always @(negedge clk) begin
		m_axis_tready = stall_on ? (($urandom % 4) == 0) : 1'b1;
	end

	task automatic check_beat(input string name, input beat_t got, input beat_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got data %h last %h, expected data %h last %h",
				name, got.data, got.last, exp.data, exp.last);
		end
	endtask

	task automatic check_phv(input string name, input phv_t got, input phv_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// unroll the data file into beat queues
	task automatic load_tests();
		int    ptr;
		int    pkts;
		int    reps;
		int    start;
		int    n;
		int    nout;
		beat_t b;
		$readmemh("verif/rmt_testdata.hex", td);
		vlan_drop_flags = td[0][FLAG_W-1:0];
		num_tests = int'(td[1]);
		ptr = 2;
		for (int t = 0; t < num_tests; t++) begin
			pkts = int'(td[ptr]);
			reps = int'(td[ptr+1]);
			test_mode[t] = int'(td[ptr+2]);
			ptr += 3;
			start = ptr;
			for (int r = 0; r < reps; r++) begin
				ptr = start;
				for (int p = 0; p < pkts; p++) begin
					n = int'(td[ptr]);
					nout = int'(td[ptr+1]);
					ptr += 2;
					for (int i = 0; i < n; i++) begin
						b.data = td[ptr+i];
						b.last = (i == n - 1);
						in_q.push_back(b);
						in_test.push_back(t);
						// dropped packets expect nothing
						if (nout != 0) begin
							// header beat comes back rewritten
							if (i == 0) begin
								b.data = td[ptr+n];
								exp_phv.push_back(td[ptr+n][PHV_W-1:0]);
							end
							exp_q.push_back(b);
							exp_hdr.push_back(i == 0);
						end
					end
					ptr += n + 1;
				end
			end
			exp_cum[t] = exp_q.size();
		end
	endtask

	// holds the beat from a falling edge until it is taken
	task automatic drive_beat(input beat_t b);
		bit took;
		s_axis_tdata = b.data;
		s_axis_tlast = b.last;
		s_axis_tvalid = 1'b1;
		do begin
			@(posedge clk);
			took = s_axis_tready;
			if (!took) begin
				ready_fell = 1'b1;
			end
			@(negedge clk);
		end while (!took);
		s_axis_tvalid = 1'b0;
	endtask

	// output monitor sampling each transfer at the rising edge
	always @(posedge clk) begin
		beat_t got;
		if (aresetn && m_axis_tvalid && m_axis_tready) begin
			got.data = m_axis_tdata;
			got.last = m_axis_tlast;
			if (exp_q.size() == 0) begin
				errors++;
				$display("output beat %h arrived with none expected", m_axis_tdata);
			end else begin
				check_beat("m_axis_tdata/m_axis_tlast", got, exp_q.pop_front());
				if (exp_hdr.pop_front()) begin
					check_phv("m_axis_tdata header vector",
						phv_t'(m_axis_tdata[PHV_W-1:0]), exp_phv.pop_front());
				end
				rcvd++;
			end
		end
	end

	initial begin
		beat_t b;
		int    errs_before;
		aresetn = 1'b0;
		s_axis_tdata = '0;
		s_axis_tlast = 1'b0;
		s_axis_tvalid = 1'b0;
		m_axis_tready = 1'b1;
		vlan_drop_flags = '0;
		stall_on = 1'b0;
		void'($urandom(SEED));
		load_tests();
		// fifty cycles per input beat plus slack
		watchdog_cycles = 50 * in_q.size() + 1000;
		repeat (3) @(negedge clk);
		aresetn = 1'b1;
		@(negedge clk);
		if (!s_axis_tready) begin
			errors++;
			$display("s_axis_tready still low after reset was released");
		end
		for (int t = 0; t < num_tests; t++) begin
			errs_before = errors;
			stall_on = (test_mode[t] == 2);
			ready_fell = 1'b0;
			while (in_q.size() > 0 && in_test[0] == t) begin
				b = in_q.pop_front();
				void'(in_test.pop_front());
				drive_beat(b);
				// idle gap after a packet in gapped mode
				if (b.last && test_mode[t] == 0) begin
					repeat ($urandom % 4) @(negedge clk);
				end
			end
			wait (rcvd >= exp_cum[t]);
			@(negedge clk);
			if (test_mode[t] == 2 && !ready_fell) begin
				errors++;
				$display("s_axis_tready never fell while the output was stalled");
			end
			stall_on = 1'b0;
			$display("test %0d: %0d beats out, %s", t + 1, rcvd,
				(errors == errs_before) ? "ok" : "failed");
		end
		// catch any late or extra beats
		repeat (20) @(negedge clk);
		errors += UUT.u_sva.fail_count;
		$display("%0d tests, %0d checks, %0d assertion failures, %0d errors",
			num_tests, checks, UUT.u_sva.fail_count, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// watchdog sized from the loaded traffic
	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", watchdog_cycles);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: verif/rmt_testdata.hex
// word 0 drop mask, word 1 number of tests
// test: packets, repeats, mode (0 gaps, 1 back-to-back, 2 back-to-back with output stalls)
// packet: beats in, beats out (0 when dropped), input beats, expected first beat
00080100
5
// header rewrite, top container wraps
1 1 0
1 1 FFFE222233334005 0002222533354006
// multi-beat passthrough
1 1 0
3 3 0A0B0C0D0E0F0021 0123456789ABCDEF FEDCBA9876543210 0A0F0C100E110022
// filter drop, vlan low bits 08 and 13 are flagged
4 1 0
1 1 0000000000000002 0004000300020003
2 0 5555555555555108 AAAAAAAAAAAAAAAA 0
2 2 1000200030000044 00000000DEADBEEF 1004200330020045
1 0 7777777777777033 0
// back-to-back order
3 1 1
1 1 0001000100010001 0005000400030002
2 2 0100020003000A0C 1122334455667788 0104020303020A0D
1 1 8000800080000FFF 8004800380021000
// back-pressure, pair sent eight times
2 8 2
4 4 0F0F0E0E0D0D00C7 0000000000000101 0000000000000202 0000000000000303 0F130E110D0F00C8
1 1 00FF00FF00FF0010 0103010201010011
